/* hdl/core_pkg.sv */
package core_pkg;

    // Datapath and register file
    localparam int XLEN = 32;
    localparam int NUM_REGS = 8;
    localparam int REG_IDX_W = 3;

    // Both cache buses carry word addresses, byte address bits 31:2
    localparam int ADDR_WIDTH = 30;
    localparam int WORD_SIZE = 4;
    localparam int ICACHE_TAG_WIDTH = 4;
    localparam int DCACHE_TAG_WIDTH = 3;

    localparam int DCR_ADDR_WIDTH = 12;
    localparam int DCR_DATA_WIDTH = 32;
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_STARTUP_ADDR = 12'h001;
    localparam logic [DCR_ADDR_WIDTH-1:0] DCR_START = 12'h002;

    // Any opcode not listed here executes as a NOP
    localparam logic [3:0] OP_ADDI = 4'd1;
    localparam logic [3:0] OP_LW = 4'd2;
    localparam logic [3:0] OP_SW = 4'd3;
    localparam logic [3:0] OP_BNEZ = 4'd4;
    localparam logic [3:0] OP_EBREAK = 4'd15;

    // Fetch FSM states
    localparam logic [2:0] FS_IDLE = 3'd0;
    localparam logic [2:0] FS_REQUEST = 3'd1;
    localparam logic [2:0] FS_WAIT_RSP = 3'd2;
    localparam logic [2:0] FS_ISSUED = 3'd3;
    localparam logic [2:0] FS_WAIT_DONE = 3'd4;

    // Execute FSM states
    localparam logic [1:0] XS_IDLE = 2'd0;
    localparam logic [1:0] XS_REQ = 2'd1;
    localparam logic [1:0] XS_RSP = 2'd2;

    // The register field after the opcode is rd for most formats but rs2 for stores
    typedef union packed {
        struct packed {
            logic [3:0]           opcode;
            logic [REG_IDX_W-1:0] rd;
            logic [REG_IDX_W-1:0] rs1;
            logic [5:0]           pad;
            logic [15:0]          imm;
        } i_fmt;
        struct packed {
            logic [3:0]           opcode;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [5:0]           pad;
            logic [15:0]          imm;
        } s_fmt;
    } instr_t;

endpackage

/* hdl/mem_bus_if.sv */
interface mem_bus_if import core_pkg::*; #(
    parameter int TAG_WIDTH = 1
) ();

    // Request channel
    logic                  req_valid;
    logic                  req_rw;
    logic [WORD_SIZE-1:0]  req_byteen;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [XLEN-1:0]       req_data;
    logic [TAG_WIDTH-1:0]  req_tag;
    logic                  req_ready;

    // Response channel
    logic                  rsp_valid;
    logic [XLEN-1:0]       rsp_data;
    logic [TAG_WIDTH-1:0]  rsp_tag;
    logic                  rsp_ready;

    modport core (
        output req_valid, req_rw, req_byteen, req_addr, req_data, req_tag, rsp_ready,
        input  req_ready, rsp_valid, rsp_data, rsp_tag
    );

    modport mem (
        input  req_valid, req_rw, req_byteen, req_addr, req_data, req_tag, rsp_ready,
        output req_ready, rsp_valid, rsp_data, rsp_tag
    );

endinterface

/* hdl/issue_if.sv */
interface issue_if import core_pkg::*; ();

    // Fetch to execute, valid is a single-cycle pulse
    logic            valid;
    instr_t          instr;
    logic [XLEN-1:0] pc;

    // Execute to fetch, all fields qualified by done
    logic            done;
    logic            redirect;
    logic [XLEN-1:0] target;
    logic            halt;

    modport fetch (
        output valid, instr, pc,
        input  done, redirect, target, halt
    );

    modport exec (
        input  valid, instr, pc,
        output done, redirect, target, halt
    );

endinterface

/* hdl/dcr_regs.sv */
module dcr_regs import core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      write_valid,
    input  logic [DCR_ADDR_WIDTH-1:0] write_addr,
    input  logic [DCR_DATA_WIDTH-1:0] write_data,
    output logic [XLEN-1:0]           startup_addr,
    output logic                      start
);

    logic startup_wr;

    assign startup_wr = write_valid && (write_addr == DCR_STARTUP_ADDR);

    // Startup byte address, kept until it is written again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            startup_addr <= '0;
        end else if (startup_wr) begin
            startup_addr <= XLEN'(write_data);
        end
    end

    // The DCR strobe lasts one cycle, so the start pulse does too
    assign start = write_valid && (write_addr == DCR_START) && write_data[0];

endmodule

/* hdl/fetch_unit.sv */
module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic [XLEN-1:0] startup_addr,
    mem_bus_if.core         icache,
    issue_if.fetch          issue,
    output logic            busy
);

    logic [2:0]                  state;
    logic [XLEN-1:0]             pc;
    logic [ICACHE_TAG_WIDTH-1:0] tag;
    logic                        running;
    logic                        rsp_hit;
    instr_t                      instr_q;

    // Stale responses carry an older tag and are consumed without effect
    assign rsp_hit = icache.rsp_valid && icache.rsp_ready && (icache.rsp_tag == tag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FS_IDLE;
            pc <= '0;
            tag <= '0;
            running <= 1'b0;
        end else begin
            case (state)
                FS_IDLE: begin
                    // Start is only honored here, so a start while running is ignored
                    if (start) begin
                        pc <= startup_addr;
                        running <= 1'b1;
                        state <= FS_REQUEST;
                    end
                end
                FS_REQUEST: begin
                    if (icache.req_ready) begin
                        state <= FS_WAIT_RSP;
                    end
                end
                FS_WAIT_RSP: begin
                    if (rsp_hit) begin
                        tag <= tag + 1'b1;
                        state <= FS_ISSUED;
                    end
                end
                FS_ISSUED: begin
                    state <= FS_WAIT_DONE;
                end
                FS_WAIT_DONE: begin
                    if (issue.done) begin
                        if (issue.halt) begin
                            running <= 1'b0;
                            state <= FS_IDLE;
                        end else begin
                            pc <= issue.redirect ? issue.target : pc + XLEN'(WORD_SIZE);
                            state <= FS_REQUEST;
                        end
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            instr_q <= icache.rsp_data;
        end
    end

    // Fetches are plain word reads
    assign icache.req_valid = (state == FS_REQUEST);
    assign icache.req_rw = 1'b0;
    assign icache.req_byteen = '1;
    assign icache.req_addr = pc[XLEN-1:2];
    assign icache.req_data = '0;
    assign icache.req_tag = tag;
    assign icache.rsp_ready = (state == FS_WAIT_RSP);

    assign issue.valid = (state == FS_ISSUED);
    assign issue.instr = instr_q;
    assign issue.pc = pc;

    assign busy = running;

endmodule

/* hdl/exec_unit.sv */
module exec_unit import core_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    issue_if.exec   issue,
    mem_bus_if.core dcache,
    output logic sim_ebreak
);

    logic [1:0]                  state;
    logic [XLEN-1:0]             regs [NUM_REGS];
    logic [3:0]                  opcode;
    logic [REG_IDX_W-1:0]        rd;
    logic [REG_IDX_W-1:0]        rs1;
    logic [REG_IDX_W-1:0]        rs2;
    logic [15:0]                 imm;
    logic [XLEN-1:0]             imm_ext;
    logic [XLEN-1:0]             rs1_val;
    logic [XLEN-1:0]             rs2_val;
    logic [XLEN-1:0]             sum;
    logic                        is_mem;
    logic                        wr_en;
    logic [REG_IDX_W-1:0]        wr_idx;
    logic [XLEN-1:0]             wr_data;
    logic                        done_q;
    logic                        redirect_q;
    logic                        halt_q;
    logic [XLEN-1:0]             target_q;
    logic                        req_rw_q;
    logic [ADDR_WIDTH-1:0]       req_addr_q;
    logic [XLEN-1:0]             req_data_q;
    logic [DCACHE_TAG_WIDTH-1:0] req_tag_q;

    // Stores read the register after the opcode through the s_fmt view as rs2
    always_comb begin
        opcode = issue.instr.i_fmt.opcode;
        rd = issue.instr.i_fmt.rd;
        rs1 = issue.instr.i_fmt.rs1;
        imm = issue.instr.i_fmt.imm;
        rs2 = issue.instr.s_fmt.rs2;
    end

    assign imm_ext = {{(XLEN-16){imm[15]}}, imm};
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // ADDI result and load/store byte address share one adder
    assign sum = rs1_val + imm_ext;
    assign is_mem = (opcode == OP_LW) || (opcode == OP_SW);

    // Single write port, ADDI writes at issue and a load writes when its data returns
    always_comb begin
        wr_en = 1'b0;
        wr_idx = rd;
        wr_data = sum;
        if (issue.valid && (opcode == OP_ADDI)) begin
            wr_en = 1'b1;
        end else if (dcache.rsp_valid && dcache.rsp_ready) begin
            wr_en = 1'b1;
            wr_idx = dcache.rsp_tag;
            wr_data = dcache.rsp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= XS_IDLE;
            done_q <= 1'b0;
            redirect_q <= 1'b0;
            halt_q <= 1'b0;
            sim_ebreak <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                sim_ebreak <= 1'b0;
            end
            case (state)
                XS_IDLE: begin
                    if (issue.valid) begin
                        redirect_q <= (opcode == OP_BNEZ) && (rs1_val != '0);
                        halt_q <= (opcode == OP_EBREAK);
                        if (opcode == OP_EBREAK) begin
                            sim_ebreak <= 1'b1;
                        end
                        if (is_mem) begin
                            state <= XS_REQ;
                        end else begin
                            done_q <= 1'b1;
                        end
                    end
                end
                XS_REQ: begin
                    // A store completes at the handshake, a load waits for data
                    if (dcache.req_ready) begin
                        if (req_rw_q) begin
                            done_q <= 1'b1;
                            state <= XS_IDLE;
                        end else begin
                            state <= XS_RSP;
                        end
                    end
                end
                XS_RSP: begin
                    if (dcache.rsp_valid) begin
                        done_q <= 1'b1;
                        state <= XS_IDLE;
                    end
                end
                default: state <= XS_IDLE;
            endcase
        end
    end

    // Request fields are captured once at issue and held through back-pressure
    always_ff @(posedge clk) begin
        if ((state == XS_IDLE) && issue.valid) begin
            target_q <= issue.pc + {imm_ext[XLEN-3:0], 2'b00};
            req_rw_q <= (opcode == OP_SW);
            req_addr_q <= sum[XLEN-1:2];
            req_data_q <= rs2_val;
            req_tag_q <= rd;
        end
    end

    assign dcache.req_valid = (state == XS_REQ);
    assign dcache.req_rw = req_rw_q;
    assign dcache.req_byteen = '1;
    assign dcache.req_addr = req_addr_q;
    assign dcache.req_data = req_data_q;
    assign dcache.req_tag = req_tag_q;
    assign dcache.rsp_ready = (state == XS_RSP);

    assign issue.done = done_q;
    assign issue.redirect = redirect_q;
    assign issue.target = target_q;
    assign issue.halt = halt_q;

endmodule

/* hdl/core_top.sv */
module core_top import core_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        dcr_write_valid,
    input  logic [DCR_ADDR_WIDTH-1:0]   dcr_write_addr,
    input  logic [DCR_DATA_WIDTH-1:0]   dcr_write_data,

    output logic                        icache_req_valid,
    output logic                        icache_req_rw,
    output logic [WORD_SIZE-1:0]        icache_req_byteen,
    output logic [ADDR_WIDTH-1:0]       icache_req_addr,
    output logic [XLEN-1:0]             icache_req_data,
    output logic [ICACHE_TAG_WIDTH-1:0] icache_req_tag,
    input  logic                        icache_req_ready,
    input  logic                        icache_rsp_valid,
    input  logic [XLEN-1:0]             icache_rsp_data,
    input  logic [ICACHE_TAG_WIDTH-1:0] icache_rsp_tag,
    output logic                        icache_rsp_ready,

    output logic                        dcache_req_valid,
    output logic                        dcache_req_rw,
    output logic [WORD_SIZE-1:0]        dcache_req_byteen,
    output logic [ADDR_WIDTH-1:0]       dcache_req_addr,
    output logic [XLEN-1:0]             dcache_req_data,
    output logic [DCACHE_TAG_WIDTH-1:0] dcache_req_tag,
    input  logic                        dcache_req_ready,
    input  logic                        dcache_rsp_valid,
    input  logic [XLEN-1:0]             dcache_rsp_data,
    input  logic [DCACHE_TAG_WIDTH-1:0] dcache_rsp_tag,
    output logic                        dcache_rsp_ready,

    output logic                        sim_ebreak,
    output logic                        busy
);

    logic [XLEN-1:0] startup_addr;
    logic            start;

    mem_bus_if #(.TAG_WIDTH(ICACHE_TAG_WIDTH)) icache_bus_if ();
    mem_bus_if #(.TAG_WIDTH(DCACHE_TAG_WIDTH)) dcache_bus_if ();
    issue_if issue_bus_if ();

    // Instruction cache port
    assign icache_req_valid = icache_bus_if.req_valid;
    assign icache_req_rw = icache_bus_if.req_rw;
    assign icache_req_byteen = icache_bus_if.req_byteen;
    assign icache_req_addr = icache_bus_if.req_addr;
    assign icache_req_data = icache_bus_if.req_data;
    assign icache_req_tag = icache_bus_if.req_tag;
    assign icache_bus_if.req_ready = icache_req_ready;
    assign icache_bus_if.rsp_valid = icache_rsp_valid;
    assign icache_bus_if.rsp_data = icache_rsp_data;
    assign icache_bus_if.rsp_tag = icache_rsp_tag;
    assign icache_rsp_ready = icache_bus_if.rsp_ready;

    // Data cache port
    assign dcache_req_valid = dcache_bus_if.req_valid;
    assign dcache_req_rw = dcache_bus_if.req_rw;
    assign dcache_req_byteen = dcache_bus_if.req_byteen;
    assign dcache_req_addr = dcache_bus_if.req_addr;
    assign dcache_req_data = dcache_bus_if.req_data;
    assign dcache_req_tag = dcache_bus_if.req_tag;
    assign dcache_bus_if.req_ready = dcache_req_ready;
    assign dcache_bus_if.rsp_valid = dcache_rsp_valid;
    assign dcache_bus_if.rsp_data = dcache_rsp_data;
    assign dcache_bus_if.rsp_tag = dcache_rsp_tag;
    assign dcache_rsp_ready = dcache_bus_if.rsp_ready;

    dcr_regs dcr_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_valid  (dcr_write_valid),
        .write_addr   (dcr_write_addr),
        .write_data   (dcr_write_data),
        .startup_addr (startup_addr),
        .start        (start)
    );

    fetch_unit fetch_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .startup_addr (startup_addr),
        .icache       (icache_bus_if),
        .issue        (issue_bus_if),
        .busy         (busy)
    );

    exec_unit exec_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .issue      (issue_bus_if),
        .dcache     (dcache_bus_if),
        .sim_ebreak (sim_ebreak)
    );

endmodule

/* verif/core_tb.sv */
module core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Six tests at about 200 cycles each, with a wide margin for back-pressure
    localparam int TEST_COUNT = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int TIMEOUT_CYCLES = TEST_COUNT * CYCLES_PER_TEST * 5 / 2;

    logic                        clk;
    logic                        rst_n;
    logic                        dcr_write_valid;
    logic [DCR_ADDR_WIDTH-1:0]   dcr_write_addr;
    logic [DCR_DATA_WIDTH-1:0]   dcr_write_data;
    logic                        icache_req_valid;
    logic                        icache_req_rw;
    logic [WORD_SIZE-1:0]        icache_req_byteen;
    logic [ADDR_WIDTH-1:0]       icache_req_addr;
    logic [XLEN-1:0]             icache_req_data;
    logic [ICACHE_TAG_WIDTH-1:0] icache_req_tag;
    logic                        icache_req_ready;
    logic                        icache_rsp_valid;
    logic [XLEN-1:0]             icache_rsp_data;
    logic [ICACHE_TAG_WIDTH-1:0] icache_rsp_tag;
    logic                        icache_rsp_ready;
    logic                        dcache_req_valid;
    logic                        dcache_req_rw;
    logic [WORD_SIZE-1:0]        dcache_req_byteen;
    logic [ADDR_WIDTH-1:0]       dcache_req_addr;
    logic [XLEN-1:0]             dcache_req_data;
    logic [DCACHE_TAG_WIDTH-1:0] dcache_req_tag;
    logic                        dcache_req_ready;
    logic                        dcache_rsp_valid;
    logic [XLEN-1:0]             dcache_rsp_data;
    logic [DCACHE_TAG_WIDTH-1:0] dcache_rsp_tag;
    logic                        dcache_rsp_ready;
    logic                        sim_ebreak;
    logic                        busy;

    // Memory models, word addressed
    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] dmem [1024];

    logic                        backpressure;
    logic [15:0]                 lfsr;
    logic                        i_pend = 1'b0;
    logic [ADDR_WIDTH-1:0]       i_addr;
    logic [ICACHE_TAG_WIDTH-1:0] i_tag;
    logic                        d_pend = 1'b0;
    logic [ADDR_WIDTH-1:0]       d_addr;
    logic [DCACHE_TAG_WIDTH-1:0] d_tag;
    logic                        i_stall = 1'b0;
    logic                        d_stall = 1'b0;
    logic [70:0]                 i_fields;
    logic [69:0]                 d_fields;
    logic [70:0]                 i_hold;
    logic [69:0]                 d_hold;
    int                          byte_idx;
    int                          stall_cycles = 0;
    int                          cycle_count = 0;
    int                          errors = 0;
    int                          tests_run = 0;
    int                          tests_failed = 0;
    logic [XLEN-1:0]             load_ptr;

    // Every store accepted on the dcache bus, in order
    logic [ADDR_WIDTH-1:0] st_addr [$];
    logic [XLEN-1:0]       st_data [$];
    logic [WORD_SIZE-1:0]  st_be [$];

    assign i_fields = {icache_req_rw, icache_req_byteen, icache_req_addr,
                       icache_req_data, icache_req_tag};
    assign d_fields = {dcache_req_rw, dcache_req_byteen, dcache_req_addr,
                       dcache_req_data, dcache_req_tag};

    core_top DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .dcr_write_valid   (dcr_write_valid),
        .dcr_write_addr    (dcr_write_addr),
        .dcr_write_data    (dcr_write_data),
        .icache_req_valid  (icache_req_valid),
        .icache_req_rw     (icache_req_rw),
        .icache_req_byteen (icache_req_byteen),
        .icache_req_addr   (icache_req_addr),
        .icache_req_data   (icache_req_data),
        .icache_req_tag    (icache_req_tag),
        .icache_req_ready  (icache_req_ready),
        .icache_rsp_valid  (icache_rsp_valid),
        .icache_rsp_data   (icache_rsp_data),
        .icache_rsp_tag    (icache_rsp_tag),
        .icache_rsp_ready  (icache_rsp_ready),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req_rw     (dcache_req_rw),
        .dcache_req_byteen (dcache_req_byteen),
        .dcache_req_addr   (dcache_req_addr),
        .dcache_req_data   (dcache_req_data),
        .dcache_req_tag    (dcache_req_tag),
        .dcache_req_ready  (dcache_req_ready),
        .dcache_rsp_valid  (dcache_rsp_valid),
        .dcache_rsp_data   (dcache_rsp_data),
        .dcache_rsp_tag    (dcache_rsp_tag),
        .dcache_rsp_ready  (dcache_rsp_ready),
        .sim_ebreak        (sim_ebreak),
        .busy              (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16-bit Galois LFSR, one step per bit taken
    function automatic logic next_bit();
        lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        return lfsr[0];
    endfunction

    // Field layout: opcode, register after opcode, rs1, pad, imm
    function automatic logic [31:0] encode_instr(input logic [3:0] op, input int ra,
                                                 input int rb, input int imm);
        return {op, ra[2:0], rb[2:0], 6'b0, imm[15:0]};
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0d ns: %s", $time, msg);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic emit_instr(input logic [31:0] word);
        imem[load_ptr[9:2]] = word;
        load_ptr = load_ptr + 4;
    endtask

    // Both bus models share one block so the LFSR is stepped in a fixed order
    always @(posedge clk) begin
        if (rst_n) begin
            if (i_stall && (!icache_req_valid || (i_fields !== i_hold))) begin
                report_mismatch("icache request changed while stalled");
            end
            if (d_stall && (!dcache_req_valid || (d_fields !== d_hold))) begin
                report_mismatch("dcache request changed while stalled");
            end
            i_stall = icache_req_valid && !icache_req_ready;
            d_stall = dcache_req_valid && !dcache_req_ready;
            i_hold = i_fields;
            d_hold = d_fields;
            if (i_stall || d_stall) begin
                stall_cycles++;
            end

            if (icache_rsp_valid && icache_rsp_ready) begin
                icache_rsp_valid <= 1'b0;
            end
            if (icache_req_valid && icache_req_ready) begin
                // Fetches are word reads with all byte enables and no write data
                if ((icache_req_rw !== 1'b0) || (icache_req_byteen !== 4'hF)
                        || (icache_req_data !== '0)) begin
                    report_mismatch($sformatf("fetch rw %b be %h data %h, expected 0 f 0",
                                              icache_req_rw, icache_req_byteen,
                                              icache_req_data));
                end
                i_pend = 1'b1;
                i_addr = icache_req_addr;
                i_tag = icache_req_tag;
            end
            if (i_pend && (!icache_rsp_valid || icache_rsp_ready)
                    && (!backpressure || next_bit())) begin
                icache_rsp_valid <= 1'b1;
                icache_rsp_data <= imem[i_addr[7:0]];
                icache_rsp_tag <= i_tag;
                i_pend = 1'b0;
            end
            icache_req_ready <= !backpressure || next_bit();

            if (dcache_rsp_valid && dcache_rsp_ready) begin
                dcache_rsp_valid <= 1'b0;
            end
            if (dcache_req_valid && dcache_req_ready) begin
                if (dcache_req_rw) begin
                    for (byte_idx = 0; byte_idx < WORD_SIZE; byte_idx++) begin
                        if (dcache_req_byteen[byte_idx]) begin
                            dmem[dcache_req_addr[9:0]][8*byte_idx +: 8] =
                                dcache_req_data[8*byte_idx +: 8];
                        end
                    end
                    st_addr.push_back(dcache_req_addr);
                    st_data.push_back(dcache_req_data);
                    st_be.push_back(dcache_req_byteen);
                end else begin
                    d_pend = 1'b1;
                    d_addr = dcache_req_addr;
                    d_tag = dcache_req_tag;
                end
            end
            if (d_pend && (!dcache_rsp_valid || dcache_rsp_ready)
                    && (!backpressure || next_bit())) begin
                dcache_rsp_valid <= 1'b1;
                dcache_rsp_data <= dmem[d_addr[9:0]];
                dcache_rsp_tag <= d_tag;
                d_pend = 1'b0;
            end
            dcache_req_ready <= !backpressure || next_bit();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic dcr_write(input logic [DCR_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        dcr_write_valid <= 1'b1;
        dcr_write_addr <= addr;
        dcr_write_data <= data;
        @(posedge clk);
        dcr_write_valid <= 1'b0;
    endtask

    task automatic expect_no_fetch(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (icache_req_valid) begin
                report_error("icache request appeared while the core should be idle");
            end
        end
    endtask

    // Starts the core and waits for its first fetch and then for the halt
    task automatic start_and_wait(input logic [31:0] base);
        int n;
        n = 0;
        st_addr.delete();
        st_data.delete();
        st_be.delete();
        dcr_write(DCR_START, 32'h1);
        do begin
            @(posedge clk);
            n++;
        end while (!icache_req_valid && (n < 5));
        if (!icache_req_valid) begin
            report_error("no icache request followed the start command");
        end else begin
            if (n != 1) begin
                report_mismatch($sformatf("first fetch %0d cycles after start, expected 1",
                                          n));
            end
            if (icache_req_addr !== base[31:2]) begin
                report_mismatch($sformatf("first fetch addr %h, expected %h",
                                          icache_req_addr, base[31:2]));
            end
            if (sim_ebreak || !busy) begin
                report_mismatch("sim_ebreak or busy wrong after start");
            end
        end
        while (busy) begin
            @(posedge clk);
        end
        if (!sim_ebreak) begin
            report_mismatch("sim_ebreak low after the core stopped");
        end
    endtask

    task automatic run_program(input logic [31:0] base);
        dcr_write(DCR_STARTUP_ADDR, base);
        start_and_wait(base);
    endtask

    task automatic check_store(input int idx, input logic [31:0] byte_addr,
                               input logic [31:0] data);
        if (idx >= st_addr.size()) begin
            report_error($sformatf("store %0d never arrived", idx));
        end else if ((st_addr[idx] !== byte_addr[31:2]) || (st_data[idx] !== data)
                || (st_be[idx] !== 4'hF)) begin
            report_mismatch($sformatf("store %0d addr %h data %h be %h, expected %h %h f",
                                      idx, st_addr[idx], st_data[idx], st_be[idx],
                                      byte_addr[31:2], data));
        end
    endtask

    task automatic check_store_count(input int expected);
        if (st_addr.size() != expected) begin
            report_mismatch($sformatf("%0d stores seen, expected %0d",
                                      st_addr.size(), expected));
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    task automatic test_reset_config();
        int e;
        e = errors;
        if (icache_req_valid || dcache_req_valid || busy || sim_ebreak
                || icache_rsp_ready || dcache_rsp_ready) begin
            report_mismatch("outputs not idle after reset");
        end
        load_ptr = 32'h100;
        emit_instr(encode_instr(OP_EBREAK, 0, 0, 0));
        dcr_write(12'h007, 32'h1);
        expect_no_fetch(10);
        dcr_write(DCR_STARTUP_ADDR, 32'h100);
        expect_no_fetch(10);
        start_and_wait(32'h100);
        finish_test("reset_config", e);
    endtask

    task automatic test_addi_sw();
        int e;
        e = errors;
        load_ptr = 32'h000;
        emit_instr(encode_instr(OP_ADDI, 1, 0, 100));
        emit_instr(encode_instr(OP_ADDI, 2, 1, -7));
        emit_instr(encode_instr(OP_ADDI, 0, 1, 5));
        emit_instr(encode_instr(OP_SW, 1, 0, 32'h200));
        emit_instr(encode_instr(OP_SW, 2, 1, 32'h20));
        emit_instr(encode_instr(OP_SW, 0, 0, 32'h204));
        emit_instr(encode_instr(OP_ADDI, 3, 2, -200));
        emit_instr(encode_instr(OP_SW, 3, 0, 32'h208));
        emit_instr(encode_instr(OP_EBREAK, 0, 0, 0));
        run_program(32'h000);
        check_store_count(4);
        check_store(0, 32'h200, 32'd100);
        // Base r1 holds 100, so the second store lands at 100 + 0x20
        check_store(1, 32'd100 + 32'h20, 32'd93);
        check_store(2, 32'h204, 32'd0);
        check_store(3, 32'h208, 32'd93 - 32'd200);
        finish_test("addi_sw", e);
    endtask

    task automatic test_load();
        int e;
        logic [31:0] a_word;
        logic [31:0] b_word;
        e = errors;
        a_word = dmem[10'h100];
        b_word = dmem[10'h101];
        load_ptr = 32'h040;
        emit_instr(encode_instr(OP_ADDI, 4, 0, 32'h400));
        emit_instr(encode_instr(OP_LW, 5, 4, 0));
        emit_instr(encode_instr(OP_LW, 6, 4, 4));
        emit_instr(encode_instr(OP_SW, 5, 4, 32'h20));
        emit_instr(encode_instr(OP_SW, 6, 4, 32'h24));
        emit_instr(encode_instr(OP_EBREAK, 0, 0, 0));
        run_program(32'h040);
        check_store_count(2);
        if ((dmem[10'h108] !== a_word) || (dmem[10'h109] !== b_word)) begin
            report_mismatch($sformatf("copied words %h %h, expected %h %h",
                                      dmem[10'h108], dmem[10'h109], a_word, b_word));
        end
        finish_test("load", e);
    endtask

    // Counts r1 down from 5, storing it on each pass of the loop
    task automatic run_countdown(input string name);
        int e;
        e = errors;
        load_ptr = 32'h080;
        emit_instr(encode_instr(OP_ADDI, 1, 0, 5));
        emit_instr(encode_instr(OP_SW, 1, 0, 32'h300));
        emit_instr(encode_instr(OP_ADDI, 1, 1, -1));
        emit_instr(encode_instr(OP_BNEZ, 0, 1, -2));
        emit_instr(encode_instr(OP_EBREAK, 0, 0, 0));
        run_program(32'h080);
        check_store_count(5);
        for (int i = 0; i < 5; i++) begin
            check_store(i, 32'h300, 32'(5 - i));
        end
        if (backpressure && (stall_cycles == 0)) begin
            report_error("back-pressure never stalled a request");
        end
        finish_test(name, e);
    endtask

    task automatic test_backpressure();
        stall_cycles = 0;
        backpressure <= 1'b1;
        run_countdown("backpressure");
        backpressure <= 1'b0;
    endtask

    task automatic test_restart();
        int e;
        e = errors;
        if (!sim_ebreak || busy) begin
            report_mismatch("core not halted before restart");
        end
        expect_no_fetch(50);
        load_ptr = 32'h200;
        emit_instr(encode_instr(OP_ADDI, 2, 0, 32'h55));
        emit_instr(encode_instr(OP_SW, 2, 0, 32'h310));
        emit_instr(encode_instr(OP_EBREAK, 0, 0, 0));
        run_program(32'h200);
        check_store_count(1);
        check_store(0, 32'h310, 32'h55);
        finish_test("restart", e);
    endtask

    initial begin
        rst_n = 1'b0;
        dcr_write_valid = 1'b0;
        dcr_write_addr = '0;
        dcr_write_data = '0;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_data = '0;
        icache_rsp_tag = '0;
        dcache_req_ready = 1'b0;
        dcache_rsp_valid = 1'b0;
        dcache_rsp_data = '0;
        dcache_rsp_tag = '0;
        backpressure = 1'b0;
        lfsr = 16'd45;
        // Unused instruction words halt the core, data words hash their address
        for (int i = 0; i < 256; i++) begin
            imem[i] = {OP_EBREAK, 28'(i)};
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 32'h5A00_0000 ^ (32'(i) * 32'h9E37_79B9);
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_reset_config();
        test_addi_sw();
        test_load();
        run_countdown("bnez_loop");
        test_backpressure();
        test_restart();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/core_pkg.sv
hdl/mem_bus_if.sv
hdl/issue_if.sv
hdl/dcr_regs.sv
hdl/fetch_unit.sv
hdl/exec_unit.sv
hdl/core_top.sv
verif/core_tb.sv
